//--- Makefile
# Verilator build, run and lint for the AXI4-Stream packet source

VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= stream_src_tb
RTL_TOP   ?= stream_src_top
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= $(OBJ_DIR)/V$(TB_TOP)
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# the log decides the result, the simulator exit code is not used
run: build
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- axis_skid_out.sv
`timescale 1ns/10ps
`include "stream_src_config.svh"

module axis_skid_out
  import stream_src_pkg::*;
(
  input  logic                            M_AXIS_ACLK,
  input  logic                            M_AXIS_ARESETN,
  input  logic                            gen_valid,
  input  axis_beat_t                      gen_beat,
  input  logic                            m_axis_tready,
  output logic                            gen_ready,
  output logic                            m_axis_tvalid,
  output logic [`STREAM_DATA_WIDTH-1:0]   m_axis_tdata,
  output logic [`STREAM_DATA_WIDTH/8-1:0] m_axis_tstrb,
  output logic                            m_axis_tlast
);

  // occupancy of the main and skid entries, 0 to 2
  logic [1:0] occ;
  axis_beat_t main_q;
  axis_beat_t skid_q;
  logic       in_xfer;
  logic       out_xfer;

  ////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////

  // ready only depends on registered state, so TREADY never reaches
  // the generator combinationally
  assign gen_ready     = (occ != 2'd2);
  assign m_axis_tvalid = (occ != 2'd0);
  assign in_xfer       = gen_valid && gen_ready;
  assign out_xfer      = m_axis_tvalid && m_axis_tready;

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      occ <= '0;
    end else begin
      occ <= occ + {1'b0, in_xfer} - {1'b0, out_xfer};
    end
  end

  ////////////////////////////////////////////////////////////
  // entry registers
  ////////////////////////////////////////////////////////////

  // main always holds the oldest beat, skid only fills when a beat
  // arrives while main is stalled on the port
  always_ff @(posedge M_AXIS_ACLK) begin
    if (occ == 2'd2) begin
      if (out_xfer) begin
        main_q <= skid_q;
      end
    end else if (in_xfer) begin
      if (occ == 2'd0 || out_xfer) begin
        main_q <= gen_beat;
      end else begin
        skid_q <= gen_beat;
      end
    end
  end

  assign m_axis_tdata = main_q.data;
  assign m_axis_tstrb = main_q.strb;
  assign m_axis_tlast = main_q.last;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // AXI4-Stream rule, an offered transfer holds until taken
  a_axis_hold: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable({m_axis_tdata, m_axis_tstrb, m_axis_tlast}))
  );

endmodule

//--- flist.f
+incdir+.
stream_src_pkg.sv
frame_scheduler.sv
payload_generator.sv
axis_skid_out.sv
stream_src_top.sv
stream_src_tb.sv

//--- frame_scheduler.sv
`timescale 1ns/10ps
`include "stream_src_config.svh"

module frame_scheduler
  import stream_src_pkg::*;
(
  input  logic M_AXIS_ACLK,
  input  logic M_AXIS_ARESETN,
  input  logic frame_done,
  output logic frame_start
);

  // one spare bit so a start count of 1 still gets a usable counter
  localparam int cnt_bits = $clog2(`STREAM_START_COUNT + 1);
  localparam logic [cnt_bits-1:0] cnt_last = cnt_bits'(`STREAM_START_COUNT - 1);

  sched_state_e        state;
  logic [cnt_bits-1:0] delay_cnt;
  logic                delay_done;

  assign delay_done = (delay_cnt == cnt_last);

  ////////////////////////////////////////////////////////////
  // frame sequencing
  ////////////////////////////////////////////////////////////

  // idle lasts exactly one cycle and clears the counter, start_wait
  // then covers counts 0 up to cnt_last before the start strobe
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state       <= idle;
      delay_cnt   <= '0;
      frame_start <= 1'b0;
    end else begin
      frame_start <= 1'b0;
      case (state)
        idle: begin
          delay_cnt <= '0;
          state     <= start_wait;
        end
        start_wait: begin
          if (delay_done) begin
            frame_start <= 1'b1;
            state       <= frame_busy;
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
          end
        end
        frame_busy: begin
          // the generator reports the end of its frame here
          if (frame_done) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // a done strobe outside frame_busy means the two stages lost step
  a_done_in_busy: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    frame_done |-> (state == frame_busy)
  );

endmodule

//--- payload_generator.sv
`timescale 1ns/10ps
`include "stream_src_config.svh"

module payload_generator
  import stream_src_pkg::*;
(
  input  logic       M_AXIS_ACLK,
  input  logic       M_AXIS_ARESETN,
  input  logic       frame_start,
  input  logic       gen_ready,
  output logic       gen_valid,
  output axis_beat_t gen_beat,
  output logic       frame_done
);

  localparam int half_bits = `STREAM_DATA_WIDTH / 2;
  localparam int ptr_bits  = $clog2(`STREAM_FRAME_WORDS + 1);
  localparam logic [ptr_bits-1:0] ptr_last = ptr_bits'(`STREAM_FRAME_WORDS - 1);

  gen_state_e           state;
  logic [ptr_bits-1:0]  word_ptr;
  logic [half_bits-1:0] frame_num;
  logic                 beat_xfer;
  logic                 last_word;

  assign gen_valid = (state == gen_send);
  assign beat_xfer = gen_valid && gen_ready;
  assign last_word = (word_ptr == ptr_last);

  ////////////////////////////////////////////////////////////
  // beat formation
  ////////////////////////////////////////////////////////////

  // frame number on top, 1-based word index below
  always_comb begin
    gen_beat.data = {frame_num, half_bits'(word_ptr) + half_bits'(1)};
    gen_beat.strb = '1;
    gen_beat.last = last_word;
  end

  ////////////////////////////////////////////////////////////
  // word pointer and frame count
  ////////////////////////////////////////////////////////////

  // the pointer only moves on an accepted beat, so a stalled beat
  // stays on gen_beat until the output register takes it
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state      <= gen_idle;
      word_ptr   <= '0;
      frame_num  <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      case (state)
        gen_idle: begin
          if (frame_start) begin
            state <= gen_send;
          end
        end
        gen_send: begin
          if (beat_xfer) begin
            if (last_word) begin
              word_ptr   <= '0;
              frame_num  <= frame_num + 1'b1;
              frame_done <= 1'b1;
              state      <= gen_idle;
            end else begin
              word_ptr <= word_ptr + 1'b1;
            end
          end
        end
        default: begin
          state <= gen_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // the scheduler must never restart a frame that is still running
  a_start_when_idle: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    frame_start |-> (state == gen_idle)
  );

  // a refused beat is offered again unchanged
  a_beat_hold: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    (gen_valid && !gen_ready) |=> (gen_valid && $stable(gen_beat))
  );

endmodule

//--- stream_src_config.svh
`ifndef STREAM_SRC_CONFIG_SVH
`define STREAM_SRC_CONFIG_SVH

////////////////////////////////////////////////////////////
// stream source build constants
////////////////////////////////////////////////////////////

// width of one AXI4-Stream word in bits
`define STREAM_DATA_WIDTH 32

// cycles spent in start_wait ahead of every frame
`define STREAM_START_COUNT 32

// beats per frame, the last one carries TLAST
`define STREAM_FRAME_WORDS 8

`endif

//--- stream_src_pkg.sv
`include "stream_src_config.svh"

package stream_src_pkg;

  ////////////////////////////////////////////////////////////
  // state encodings
  ////////////////////////////////////////////////////////////

  // frame scheduler, one idle cycle then the start-up delay
  typedef enum logic [1:0] {
    idle       = 2'd0,
    start_wait = 2'd1,
    frame_busy = 2'd2
  } sched_state_e;

  // payload generator, either waiting for a start strobe or sending
  typedef enum logic {
    gen_idle = 1'b0,
    gen_send = 1'b1
  } gen_state_e;

  ////////////////////////////////////////////////////////////
  // stream beat
  ////////////////////////////////////////////////////////////

  // one AXI4-Stream transfer as it moves between the generator and
  // the output register, data sits in the upper bits
  typedef struct packed {
    logic [`STREAM_DATA_WIDTH-1:0]   data;
    logic [`STREAM_DATA_WIDTH/8-1:0] strb;
    logic                            last;
  } axis_beat_t;

endpackage

//--- stream_src_tb_util.svh
`ifndef STREAM_SRC_TB_UTIL_SVH
`define STREAM_SRC_TB_UTIL_SVH

////////////////////////////////////////////////////////////
// random numbers
////////////////////////////////////////////////////////////

// right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'h8020_0003;
  end
  return n;
endfunction

// one LFSR step for every bit taken, the first bit ends up on top
task automatic draw_bits(input int n, output int value);
  value = 0;
  for (int i = 0; i < n; i++) begin
    value = (value << 1) | int'(lfsr_q[0]);
    lfsr_q = lfsr_next(lfsr_q);
  end
endtask

////////////////////////////////////////////////////////////
// result checks
////////////////////////////////////////////////////////////

task automatic compare_beat(
  input string      name,
  input axis_beat_t expected,
  input axis_beat_t actual
);
  if (actual !== expected) begin
    $display("MISMATCH %s expected data=%h strb=%h last=%b actual data=%h strb=%h last=%b",
             name, expected.data, expected.strb, expected.last,
             actual.data, actual.strb, actual.last);
    abort_run();
  end
endtask

task automatic compare_count(
  input string name,
  input int    expected,
  input int    actual
);
  if (actual != expected) begin
    $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
    abort_run();
  end
endtask

`endif

//--- stream_src_tb.sv
`timescale 1ns/10ps
`include "stream_src_config.svh"

module stream_src_tb
  import stream_src_pkg::*;
();

  localparam int num_frames    = 20;
  localparam int frame_timeout = 2000;
  localparam int drain_timeout = 200;
  localparam int half_bits     = `STREAM_DATA_WIDTH / 2;

  logic                            M_AXIS_ACLK;
  logic                            M_AXIS_ARESETN;
  logic                            m_axis_tvalid;
  logic [`STREAM_DATA_WIDTH-1:0]   m_axis_tdata;
  logic [`STREAM_DATA_WIDTH/8-1:0] m_axis_tstrb;
  logic                            m_axis_tlast;
  logic                            m_axis_tready;

  logic [31:0] lfsr_q;

  // frame model and port bookkeeping
  int         cycle_cnt    = 0;
  int         exp_frame    = 0;
  int         exp_word     = 0;
  int         beat_cnt     = 0;
  int         frames_seen  = 0;
  int         gap_cycles   = 0;
  int         stall_cycles = 0;
  bit         in_frame     = 1'b0;
  bit         first_seen   = 1'b0;
  bit         prev_stalled = 1'b0;
  axis_beat_t prev_beat;

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  `include "stream_src_tb_util.svh"

  stream_src_top DUT (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tstrb   (m_axis_tstrb),
    .m_axis_tlast   (m_axis_tlast),
    .m_axis_tready  (m_axis_tready)
  );

  ////////////////////////////////////////////////////////////
  // clock and TREADY
  ////////////////////////////////////////////////////////////

  initial begin
    M_AXIS_ACLK = 1'b0;
    forever #20 M_AXIS_ACLK = ~M_AXIS_ACLK;
  end

  always @(posedge M_AXIS_ACLK) begin
    if (M_AXIS_ARESETN) begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  // mostly short random gaps and now and then a long stall of 9 to 40 cycles
  initial begin
    int r;
    int stall_left;
    bit run;
    m_axis_tready = 1'b0;
    lfsr_q        = 32'h1630;
    stall_left    = 0;
    forever begin
      @(posedge M_AXIS_ACLK);
      run = M_AXIS_ARESETN;
      #2;
      if (!run) begin
        m_axis_tready = 1'b0;
      end else if (stall_left > 0) begin
        m_axis_tready = 1'b0;
        stall_left--;
      end else begin
        draw_bits(4, r);
        if (r == 0) begin
          draw_bits(5, r);
          stall_left    = 8 + r;
          m_axis_tready = 1'b0;
        end else begin
          m_axis_tready = (r >= 5);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // port monitor
  ////////////////////////////////////////////////////////////

  always @(negedge M_AXIS_ACLK) begin
    axis_beat_t act;
    axis_beat_t exp;
    if (M_AXIS_ARESETN) begin
      act = {m_axis_tdata, m_axis_tstrb, m_axis_tlast};
      if (prev_stalled) begin
        if (!m_axis_tvalid) begin
          $display("TVALID dropped while a beat was still waiting for TREADY");
          abort_run();
        end
        compare_beat("hold", prev_beat, act);
      end
      if (m_axis_tvalid && !in_frame) begin
        if (!first_seen) begin
          if (cycle_cnt < `STREAM_START_COUNT + 2) begin
            $display("first TVALID came %0d cycles after reset, too early", cycle_cnt);
            abort_run();
          end
          first_seen = 1'b1;
        // the next start-up delay already runs while the tail of a frame
        // waits on the port, so refused cycles count toward the gap
        end else if (gap_cycles + stall_cycles < `STREAM_START_COUNT) begin
          $display("frame %0d started only %0d idle and %0d stalled cycles after TLAST",
                   exp_frame, gap_cycles, stall_cycles);
          abort_run();
        end
        in_frame     = 1'b1;
        stall_cycles = 0;
      end
      if (!m_axis_tvalid && !in_frame) begin
        gap_cycles++;
      end
      if (m_axis_tvalid && !m_axis_tready) begin
        stall_cycles++;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        beat_cnt++;
        // an early TLAST shows up as a short frame
        if (act.last) begin
          compare_count("frame_length", `STREAM_FRAME_WORDS, beat_cnt);
        end
        exp.data = {half_bits'(exp_frame), half_bits'(exp_word + 1)};
        exp.strb = '1;
        exp.last = (exp_word + 1 == `STREAM_FRAME_WORDS);
        compare_beat("beat", exp, act);
        if (act.last) begin
          frames_seen++;
          exp_frame++;
          exp_word   = 0;
          beat_cnt   = 0;
          gap_cycles = 0;
          in_frame   = 1'b0;
        end else begin
          exp_word++;
        end
      end
      prev_stalled = m_axis_tvalid && !m_axis_tready;
      prev_beat    = act;
    end
  end

  ////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////

  initial begin
    int waited;
    M_AXIS_ARESETN = 1'b0;
    repeat (4) @(posedge M_AXIS_ACLK);
    #2;
    M_AXIS_ARESETN = 1'b1;

    for (int f = 1; f <= num_frames; f++) begin
      waited = 0;
      while (frames_seen < f && waited < frame_timeout) begin
        @(posedge M_AXIS_ACLK);
        waited++;
      end
      if (frames_seen < f) begin
        $display("no TLAST for frame %0d within %0d cycles", f - 1, frame_timeout);
        abort_run();
      end
    end

    // the port should be idle between frames once the last TLAST is taken
    waited = 0;
    while ((in_frame || m_axis_tvalid) && waited < drain_timeout) begin
      @(negedge M_AXIS_ACLK);
      waited++;
    end
    if (in_frame || m_axis_tvalid) begin
      $display("port still busy %0d cycles after the last frame", drain_timeout);
      abort_run();
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- stream_src_top.sv
`timescale 1ns/10ps
`include "stream_src_config.svh"

module stream_src_top
  import stream_src_pkg::*;
(
  input  logic                            M_AXIS_ACLK,
  input  logic                            M_AXIS_ARESETN,
  output logic                            m_axis_tvalid,
  output logic [`STREAM_DATA_WIDTH-1:0]   m_axis_tdata,
  output logic [`STREAM_DATA_WIDTH/8-1:0] m_axis_tstrb,
  output logic                            m_axis_tlast,
  input  logic                            m_axis_tready
);

  logic       frame_start;
  logic       frame_done;
  logic       gen_valid;
  logic       gen_ready;
  axis_beat_t gen_beat;

  ////////////////////////////////////////////////////////////
  // scheduler, generator, output register
  ////////////////////////////////////////////////////////////

  frame_scheduler u_sched (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .frame_done     (frame_done),
    .frame_start    (frame_start)
  );

  payload_generator u_gen (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .frame_start    (frame_start),
    .gen_ready      (gen_ready),
    .gen_valid      (gen_valid),
    .gen_beat       (gen_beat),
    .frame_done     (frame_done)
  );

  // the only stage that sees the external port
  axis_skid_out u_out (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .gen_valid      (gen_valid),
    .gen_beat       (gen_beat),
    .m_axis_tready  (m_axis_tready),
    .gen_ready      (gen_ready),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tstrb   (m_axis_tstrb),
    .m_axis_tlast   (m_axis_tlast)
  );

endmodule
